/* common/motion_settings.svh */
`ifndef MOTION_SETTINGS_SVH
`define MOTION_SETTINGS_SVH

// Bus widths
`define WB_DATA_BITS 32
`define WB_ADDR_BITS 8

// Move duration counter, in clock cycles
`define MOVE_DURATION_BITS 24

// Step increment and phase accumulator share one width
`define RATE_BITS 16

// Commanded and encoder positions
`define POS_BITS 32

`define FOLLOW_LIMIT_RESET 64

`endif

/* common/bus_pkg.sv */
`include "motion_settings.svh"

package bus_pkg;

  typedef logic [`WB_DATA_BITS-1:0] wb_data_t;
  typedef logic [`WB_ADDR_BITS-1:0] wb_addr_t;

  // Byte addresses, 32-bit accesses only
  typedef enum logic [`WB_ADDR_BITS-1:0] {
    CTRL       = 8'h00,
    RATE       = 8'h04,
    DURATION   = 8'h08,
    LIMIT      = 8'h0C,
    STATUS     = 8'h10,
    CMD_POS    = 8'h14,
    ENC_POS    = 8'h18,
    FOLLOW_ERR = 8'h1C
  } reg_addr_e;

  // CTRL bit positions
  localparam int CTRL_ENABLE = 0;
  localparam int CTRL_START  = 1; // Strobe
  localparam int CTRL_CLEAR  = 2; // Strobe
  localparam int CTRL_DIR    = 3;

endpackage

/* common/motion_pkg.sv */
`include "motion_settings.svh"

package motion_pkg;

  typedef logic signed [`POS_BITS-1:0]     pos_t;
  typedef logic [`RATE_BITS-1:0]           rate_t;
  typedef logic [`MOVE_DURATION_BITS-1:0]  duration_t;

  // First member lands in the top bit, so busy sits at bit 0
  typedef struct packed {
    logic enable_out;
    logic enc_fault;
    logic follow_fault;
    logic busy;
  } motion_status_t;

  // Magnitude of a signed position
  function automatic pos_t pos_abs(pos_t value);
    pos_t result;
    if (value < 0) begin
      result = -value;
    end else begin
      result = value;
    end
    return result;
  endfunction

endpackage

/* stepper/step_timer.sv */
`timescale 1ns/10ps
`include "motion_settings.svh"

module step_timer (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  move_start,
  input  logic                  move_dir,
  input  logic                  enable_out,
  input  motion_pkg::rate_t     move_rate,
  input  motion_pkg::duration_t move_duration,
  output logic                  step_pulse,
  output logic                  dir,
  output logic                  busy
);

  import motion_pkg::*;

  rate_t              acc;
  rate_t              rate_q;
  duration_t          remaining;
  logic [`RATE_BITS:0] acc_sum;
  logic               accept;

  // Start only from idle with the driver enabled
  assign accept = move_start & ~busy & enable_out;

  assign acc_sum = {1'b0, acc} + {1'b0, rate_q};

  // Carry out of the accumulator is the step, in the cycle of the add
  assign step_pulse = busy & enable_out & acc_sum[`RATE_BITS];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      acc       <= '0;
      rate_q    <= '0;
      remaining <= '0;
      dir       <= 1'b0;
      busy      <= 1'b0;
    end else if (accept) begin
      acc       <= '0;
      rate_q    <= move_rate;
      remaining <= move_duration;
      dir       <= move_dir;              // Held for the whole move
      busy      <= (move_duration != '0); // Zero duration gives no steps
    end else if (busy) begin
      if (!enable_out) begin
        busy <= 1'b0; // Abort
      end else begin
        acc       <= acc_sum[`RATE_BITS-1:0];
        remaining <= remaining - 1'b1;
        if (remaining == duration_t'(1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

endmodule

/* encoder/quad_decoder.sv */
`timescale 1ns/10ps

module quad_decoder (
  input  logic             CLK,
  input  logic             resetn,
  input  logic             enc_a,
  input  logic             enc_b,
  input  logic             fault_clear,
  output motion_pkg::pos_t enc_count,
  output logic             enc_fault
);

  import motion_pkg::*;

  logic [1:0] ab_meta;
  logic [1:0] ab_sync;
  logic [1:0] ab_prev;
  logic       count_up;
  logic       count_down;
  logic       illegal;

  // Two synchronizer stages, then one stage of history
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      ab_meta <= 2'b00;
      ab_sync <= 2'b00;
      ab_prev <= 2'b00;
    end else begin
      ab_meta <= {enc_a, enc_b};
      ab_sync <= ab_meta;
      ab_prev <= ab_sync;
    end
  end

  // Forward Gray order is 00, 01, 11, 10
  always_comb begin
    count_up   = 1'b0;
    count_down = 1'b0;
    illegal    = 1'b0;
    case ({ab_prev, ab_sync})
      4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count_up = 1'b1;
      4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: count_down = 1'b1;
      4'b00_11, 4'b11_00, 4'b01_10, 4'b10_01: illegal = 1'b1; // Both bits moved
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_count <= '0;
    end else if (count_up) begin
      enc_count <= enc_count + pos_t'(1);
    end else if (count_down) begin
      enc_count <= enc_count - pos_t'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_fault <= 1'b0;
    end else if (illegal) begin
      enc_fault <= 1'b1; // Sticky
    end else if (fault_clear) begin
      enc_fault <= 1'b0;
    end
  end

endmodule

/* rtl/position_monitor.sv */
`timescale 1ns/10ps

module position_monitor (
  input  logic             CLK,
  input  logic             resetn,
  input  logic             step_pulse,
  input  logic             dir,
  input  logic             drv_enable,
  input  logic             fault_clear,
  input  motion_pkg::pos_t enc_count,
  input  motion_pkg::pos_t follow_limit,
  output motion_pkg::pos_t cmd_pos,
  output motion_pkg::pos_t follow_err,
  output logic             follow_fault,
  output logic             enable_out
);

  import motion_pkg::*;

  logic over_limit;

  assign over_limit = pos_abs(follow_err) > follow_limit;

  // Host enable, dropped by a following fault
  assign enable_out = drv_enable & ~follow_fault;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cmd_pos    <= '0;
      follow_err <= '0;
    end else begin
      if (step_pulse) begin
        cmd_pos <= dir ? cmd_pos + pos_t'(1) : cmd_pos - pos_t'(1);
      end
      follow_err <= cmd_pos - enc_count;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      follow_fault <= 1'b0;
    end else if (fault_clear) begin
      follow_fault <= 1'b0; // Sets again next cycle if still over
    end else if (over_limit) begin
      follow_fault <= 1'b1;
    end
  end

endmodule

/* rtl/wb_regs.sv */
`timescale 1ns/10ps
`include "motion_settings.svh"

module wb_regs (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  bus_pkg::wb_addr_t     wb_adr,
  input  bus_pkg::wb_data_t     wb_dat_w,
  output bus_pkg::wb_data_t     wb_dat_r,
  output logic                  wb_ack,
  output logic                  move_start,
  output logic                  move_dir,
  output logic                  drv_enable,
  output logic                  fault_clear,
  output motion_pkg::rate_t     move_rate,
  output motion_pkg::duration_t move_duration,
  output motion_pkg::pos_t      follow_limit,
  input  logic                  busy,
  input  logic                  follow_fault,
  input  logic                  enc_fault,
  input  logic                  enable_out,
  input  motion_pkg::pos_t      cmd_pos,
  input  motion_pkg::pos_t      enc_count,
  input  motion_pkg::pos_t      follow_err
);

  import bus_pkg::*;
  import motion_pkg::*;

  logic           access;
  logic           wr_access;
  logic           ctrl_wr;
  logic           dir_q;
  wb_data_t       rd_data;
  motion_status_t status;

  // First cycle of a strobe; ack goes high on the next edge
  assign access    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_access = access & wb_we;
  assign ctrl_wr   = wr_access & (wb_adr == CTRL);

  // Strobes last the one cycle before the ack edge
  assign move_start  = ctrl_wr & wb_dat_w[CTRL_START];
  assign fault_clear = ctrl_wr & wb_dat_w[CTRL_CLEAR];

  // The timer latches dir on the same edge that stores it here
  assign move_dir = ctrl_wr ? wb_dat_w[CTRL_DIR] : dir_q;

  assign status.busy         = busy;
  assign status.follow_fault = follow_fault;
  assign status.enc_fault    = enc_fault;
  assign status.enable_out   = enable_out;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      drv_enable    <= 1'b0;
      dir_q         <= 1'b0;
      move_rate     <= '0;
      move_duration <= '0;
      follow_limit  <= pos_t'(`FOLLOW_LIMIT_RESET);
    end else if (wr_access) begin
      case (wb_adr)
        CTRL: begin
          drv_enable <= wb_dat_w[CTRL_ENABLE];
          dir_q      <= wb_dat_w[CTRL_DIR];
        end
        RATE:     move_rate     <= wb_dat_w[`RATE_BITS-1:0];
        DURATION: move_duration <= wb_dat_w[`MOVE_DURATION_BITS-1:0];
        LIMIT:    follow_limit  <= pos_t'(wb_dat_w);
        default: ; // Read-only or unmapped
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      CTRL: begin
        rd_data[CTRL_ENABLE] = drv_enable;
        rd_data[CTRL_DIR]    = dir_q;
      end
      RATE:       rd_data = wb_data_t'(move_rate);
      DURATION:   rd_data = wb_data_t'(move_duration);
      LIMIT:      rd_data = wb_data_t'(follow_limit);
      STATUS:     rd_data = wb_data_t'(status);
      CMD_POS:    rd_data = wb_data_t'(cmd_pos);
      ENC_POS:    rd_data = wb_data_t'(enc_count);
      FOLLOW_ERR: rd_data = wb_data_t'(follow_err);
      default:    rd_data = '0;
    endcase
  end

  // Captured with the ack edge, held until the next read
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wb_dat_r <= '0;
    end else if (access && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

/* rtl/motion_core.sv */
`timescale 1ns/10ps

module motion_core (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  bus_pkg::wb_addr_t wb_adr,
  input  bus_pkg::wb_data_t wb_dat_w,
  output bus_pkg::wb_data_t wb_dat_r,
  output logic              wb_ack,
  input  logic              enc_a,
  input  logic              enc_b,
  output logic              step,
  output logic              dir,
  output logic              enable
);

  import motion_pkg::*;

  logic      move_start;
  logic      move_dir;
  logic      drv_enable;
  logic      fault_clear;
  rate_t     move_rate;
  duration_t move_duration;
  pos_t      follow_limit;
  logic      busy;
  pos_t      enc_count;
  logic      enc_fault;
  pos_t      cmd_pos;
  pos_t      follow_err;
  logic      follow_fault;

  wb_regs u_wb_regs (
    .CLK           (CLK),
    .resetn        (resetn),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .move_start    (move_start),
    .move_dir      (move_dir),
    .drv_enable    (drv_enable),
    .fault_clear   (fault_clear),
    .move_rate     (move_rate),
    .move_duration (move_duration),
    .follow_limit  (follow_limit),
    .busy          (busy),
    .follow_fault  (follow_fault),
    .enc_fault     (enc_fault),
    .enable_out    (enable),
    .cmd_pos       (cmd_pos),
    .enc_count     (enc_count),
    .follow_err    (follow_err)
  );

  step_timer u_step_timer (
    .CLK           (CLK),
    .resetn        (resetn),
    .move_start    (move_start),
    .move_dir      (move_dir),
    .enable_out    (enable),
    .move_rate     (move_rate),
    .move_duration (move_duration),
    .step_pulse    (step),
    .dir           (dir),
    .busy          (busy)
  );

  quad_decoder u_quad_decoder (
    .CLK         (CLK),
    .resetn      (resetn),
    .enc_a       (enc_a),
    .enc_b       (enc_b),
    .fault_clear (fault_clear),
    .enc_count   (enc_count),
    .enc_fault   (enc_fault)
  );

  // Driver enable pin comes from here, gated by the following fault
  position_monitor u_position_monitor (
    .CLK          (CLK),
    .resetn       (resetn),
    .step_pulse   (step),
    .dir          (dir),
    .drv_enable   (drv_enable),
    .fault_clear  (fault_clear),
    .enc_count    (enc_count),
    .follow_limit (follow_limit),
    .cmd_pos      (cmd_pos),
    .follow_err   (follow_err),
    .follow_fault (follow_fault),
    .enable_out   (enable)
  );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
  output logic CLK,
  output logic resetn
);

  localparam real HALF_PERIOD = 4.0; // 8 ns clock

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  initial begin
    resetn = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    resetn = 1'b1; // Released just after an edge
  end

endmodule

/* dv/motion_core_props.sv */
`timescale 1ns/10ps

module motion_core_props (
  input logic CLK,
  input logic resetn,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic busy,
  input logic step,
  input logic enable
);

  // Ack is a one-cycle pulse that answers a strobe
  ack_one_cycle: assert property (@(posedge CLK) disable iff (!resetn) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for a second cycle");

  ack_after_stb: assert property (@(posedge CLK) disable iff (!resetn)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack without a preceding cyc and stb");

  step_in_move: assert property (@(posedge CLK) disable iff (!resetn) step |-> busy)
    else $error("step pulse outside a move");

  step_enabled: assert property (@(posedge CLK) disable iff (!resetn) step |-> enable)
    else $error("step pulse with the driver disabled");

endmodule

bind motion_core motion_core_props u_motion_core_props (
  .CLK    (CLK),
  .resetn (resetn),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .busy   (busy),
  .step   (step),
  .enable (enable)
);

/* dv/motion_core_tb.sv */
`timescale 1ns/10ps
`include "motion_settings.svh"

module motion_core_tb;

  import bus_pkg::*;

  localparam int ACK_TIMEOUT  = 16;
  localparam int IDLE_TIMEOUT = 400;

  logic        CLK;
  logic        resetn;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        enc_a;
  logic        enc_b;
  logic        step;
  logic        dir;
  logic        enable;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_errors = 0;
  int          step_count = 0;
  logic        exp_dir = 1'b0;
  logic [31:0] seed;
  logic [1:0]  ab; // Encoder state as {a, b}

  tb_clock u_tb_clock (
    .CLK    (CLK),
    .resetn (resetn)
  );

  motion_core u_motion_core (
    .CLK      (CLK),
    .resetn   (resetn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .enc_a    (enc_a),
    .enc_b    (enc_b),
    .step     (step),
    .dir      (dir),
    .enable   (enable)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Carries out of a 16-bit accumulator over the move
  function automatic int expected_steps(input logic [15:0] rate, input logic [23:0] cycles);
    logic [39:0] product;
    product = {24'd0, rate} * {16'd0, cycles};
    return int'(product >> 16);
  endfunction

  function automatic int expected_enc(input int start, input int fwd, input int rev);
    return start + fwd - rev;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic en, input logic start,
                                            input logic clear, input logic d);
    logic [31:0] word;
    word = '0;
    word[CTRL_ENABLE] = en;
    word[CTRL_START]  = start;
    word[CTRL_CLEAR]  = clear;
    word[CTRL_DIR]    = d;
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: gave up waiting for %s", $time, what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic wb_access(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = write;
    wb_adr   = addr;
    wb_dat_w = wdata;
    @(posedge CLK);
    #1;
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    if (!wb_ack) begin
      report_timeout("wishbone ack");
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    wb_access(1'b1, addr, data, ignored);
  endtask

  task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
    wb_access(1'b0, addr, 32'd0, data);
  endtask

  task automatic read_check(input logic [7:0] addr, input string name,
                            input logic [31:0] expected);
    logic [31:0] data;
    wb_read(addr, data);
    check_value(name, data, expected);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int polls;
    polls = 0;
    wb_read(STATUS, status);
    while (status[0] && polls < IDLE_TIMEOUT) begin
      wb_read(STATUS, status);
      polls++;
    end
    if (status[0]) begin
      report_timeout("busy to clear");
    end
  endtask

  task automatic run_move(input logic [15:0] rate, input logic [23:0] cycles, input logic d);
    exp_dir    = d;
    step_count = 0;
    wb_write(RATE, {16'd0, rate});
    wb_write(DURATION, {8'd0, cycles});
    wb_write(CTRL, ctrl_word(1'b1, 1'b1, 1'b0, d));
    wait_idle();
  endtask

  // Hold each state past the three-cycle decoder latency
  task automatic drive_ab();
    @(posedge CLK);
    #1;
    enc_a = ab[1];
    enc_b = ab[0];
    repeat (4) @(posedge CLK);
  endtask

  task automatic enc_steps(input int count, input logic forward);
    for (int i = 0; i < count; i++) begin
      case (ab)
        2'b00:   ab = forward ? 2'b01 : 2'b10;
        2'b01:   ab = forward ? 2'b11 : 2'b00;
        2'b11:   ab = forward ? 2'b10 : 2'b01;
        default: ab = forward ? 2'b00 : 2'b11;
      endcase
      drive_ab();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    test_errors = errors;
  endtask

  // Counted mid-cycle where step and dir have settled
  always @(negedge CLK) begin
    if (resetn && step) begin
      step_count++;
      check_value("dir", 32'(dir), 32'(exp_dir));
    end
  end

  initial begin : stimulus
    logic [31:0] rdata;
    logic [15:0] rate;
    logic [23:0] cycles;
    int          wait_cycles;
    int          pos;
    int          enc;
    int          err;
    int          steps;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    enc_a    = 1'b0;
    enc_b    = 1'b0;
    ab       = 2'b00;
    seed     = 32'h69df;
    wait_cycles = 0;
    while (!resetn && wait_cycles < 20) begin
      @(posedge CLK);
      wait_cycles++;
    end
    if (!resetn) begin
      report_timeout("reset release");
    end

    read_check(STATUS, "STATUS", 32'd0);
    read_check(LIMIT, "LIMIT", `FOLLOW_LIMIT_RESET);
    wb_write(RATE, 32'h0000_a5c3);
    wb_write(DURATION, 32'h00c0_ffee);
    wb_write(LIMIT, 32'h0001_2345);
    wb_write(8'h20, 32'hffff_ffff);
    read_check(RATE, "RATE", 32'h0000_a5c3);
    read_check(DURATION, "DURATION", 32'h00c0_ffee);
    read_check(LIMIT, "LIMIT", 32'h0001_2345);
    read_check(8'h20, "unmapped", 32'd0);
    end_test("register access");

    wb_write(LIMIT, 32'h7fff_ffff); // No following fault during random moves
    wb_write(CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0));
    for (int i = 0; i < 6; i++) begin
      seed   = lcg_next(seed);
      rate   = seed[31:16];
      seed   = lcg_next(seed);
      cycles = 24'd16 + {16'd0, seed[23:16]};
      wb_read(CMD_POS, rdata);
      pos = int'(rdata);
      run_move(rate, cycles, i[0]);
      steps = expected_steps(rate, cycles);
      check_value("step count", step_count, steps);
      read_check(CMD_POS, "CMD_POS", i[0] ? pos + steps : pos - steps);
    end
    end_test("random moves");

    wb_read(CMD_POS, rdata);
    pos        = int'(rdata);
    step_count = 0;
    wb_write(CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
    wb_write(RATE, 32'h0000_8000);
    wb_write(DURATION, 32'd100);
    wb_write(CTRL, ctrl_word(1'b0, 1'b1, 1'b0, 1'b1));
    wait_idle();
    check_value("step count", step_count, 0);
    wb_write(CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b1));
    exp_dir = 1'b1;
    wb_write(CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 1'b1));
    wb_write(CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0)); // Mid-move, opposite dir
    wait_idle();
    steps = expected_steps(16'h8000, 24'd100);
    check_value("step count", step_count, steps);
    read_check(CMD_POS, "CMD_POS", pos + steps);
    end_test("start rejection");

    wb_read(ENC_POS, rdata);
    enc = int'(rdata);
    enc_steps(7, 1'b1);
    enc_steps(3, 1'b0);
    read_check(ENC_POS, "ENC_POS", expected_enc(enc, 7, 3));
    ab = ~ab;
    drive_ab();
    wb_read(STATUS, rdata);
    check_value("STATUS enc_fault", 32'(rdata[2]), 32'd1);
    read_check(ENC_POS, "ENC_POS", expected_enc(enc, 7, 3));
    wb_write(CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0));
    wb_read(STATUS, rdata);
    check_value("STATUS enc_fault", 32'(rdata[2]), 32'd0);
    end_test("encoder counting");

    wb_read(CMD_POS, rdata);
    pos = int'(rdata);
    wb_read(ENC_POS, rdata);
    enc = int'(rdata);
    steps = expected_steps(16'h4000, 24'd80);
    run_move(16'h4000, 24'd80, 1'b1);
    check_value("step count", step_count, steps);
    read_check(CMD_POS, "CMD_POS", pos + steps);
    read_check(ENC_POS, "ENC_POS", enc);
    err = pos + steps - enc;
    read_check(FOLLOW_ERR, "FOLLOW_ERR", err);
    enc_steps(err < 0 ? -err : err, err > 0); // Encoder catches up
    read_check(FOLLOW_ERR, "FOLLOW_ERR", 32'd0);
    wb_write(LIMIT, 32'd5);
    run_move(16'h8000, 24'd20, 1'b0);
    wb_read(STATUS, rdata);
    check_value("STATUS follow_fault", 32'(rdata[1]), 32'd1);
    check_value("enable", 32'(enable), 32'd0);
    run_move(16'h8000, 24'd20, 1'b0);
    check_value("step count", step_count, 0);
    wb_read(FOLLOW_ERR, rdata);
    err = int'(rdata);
    enc_steps(-err - 2, 1'b0); // Leaves an error of -2
    wb_write(CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0));
    wb_read(STATUS, rdata);
    check_value("STATUS follow_fault", 32'(rdata[1]), 32'd0);
    check_value("enable", 32'(enable), 32'd1);
    end_test("following error");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+common
common/bus_pkg.sv
common/motion_pkg.sv
stepper/step_timer.sv
encoder/quad_decoder.sv
rtl/position_monitor.sv
rtl/wb_regs.sv
rtl/motion_core.sv
dv/tb_clock.sv
dv/motion_core_props.sv
dv/motion_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module motion_core_tb -f list.f -o motion_core_sim

./obj_dir/motion_core_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
